/* bench/strassenTb.sv */
`timescale 1ns/1ns
`default_nettype none

module strassenTb;

    localparam int numRuns      = 43;   // Mode 2, mode 4, invalid mode, 40 back-to-back
    localparam int cyclesPerRun = 80;   // Load, compute and readout
    localparam int latencyBrute = 5;
    localparam int latencyStr   = 9;

    logic clk;
    logic reset;
    logic start;
    logic [3:0] mode;
    logic memWrite;
    logic memSelB;
    logic [strassenPkg::idxWidth-1:0] memRow;
    logic [strassenPkg::idxWidth-1:0] memCol;
    strassenPkg::elemT memData;
    logic [strassenPkg::addrWidth-1:0] resultAddr;
    logic done;
    strassenPkg::stateT state;
    strassenPkg::resultT resultOut;

    integer seed;
    int refA [4][4];
    int refB [4][4];

    strassenTop i_strassenTop (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .mode       (mode),
        .memWrite   (memWrite),
        .memSelB    (memSelB),
        .memRow     (memRow),
        .memCol     (memCol),
        .memData    (memData),
        .resultAddr (resultAddr),
        .done       (done),
        .state      (state),
        .resultOut  (resultOut)
    );

    always #5 clk = ~clk;

    // ==============================
    // Checking helpers
    // ==============================
    task automatic stopOnFailure(input string what);
        $display("%s (time %0t ns)", what, $time);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("Error at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "Simulation stopped");
        end
    endtask

    // Plain matrix product, masked and wrapped to 12 bits
    function automatic int modelElement(input int size, input int row, input int col);
        int sum;
        sum = 0;
        if (row >= size || col >= size)
            return 0;
        for (int k = 0; k < size; k++)
            sum += refA[row][k] * refB[k][col];
        return sum % 4096;
    endfunction

    // ==============================
    // Stimulus tasks
    // ==============================
    task automatic writeElement(input logic selB, input int row, input int col, input int data);
        @(posedge clk);
        #1;
        memWrite = 1'b1;
        memSelB  = selB;
        memRow   = 2'(row);
        memCol   = 2'(col);
        memData  = 4'(data);
    endtask

    task automatic loadOperands(input bit forceOutside);
        strassenPkg::elemT value;
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                value = 4'($random(seed));
                refA[i][j] = int'(value);
                value = 4'($random(seed));
                refB[i][j] = int'(value);
            end
        end
        if (forceOutside) begin
            refA[1][3] = 9;   // Outside the 2x2 corner
            refB[2][0] = 7;
            refA[3][3] = 15;
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                writeElement(1'b0, i, j, refA[i][j]);
                writeElement(1'b1, i, j, refB[i][j]);
            end
        end
        @(posedge clk);
        #1;
        memWrite = 1'b0;
    endtask

    // Start already driven in the current cycle
    task automatic waitForDone(input int latency, input bit noisyStart);
        int cycles;
        cycles = 0;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            start = noisyStart ? 1'($random(seed)) : 1'b0;  // Ignored while busy
            if (cycles > latency + 20)
                stopOnFailure("Done never arrived after start");
        end
        checkValue(cycles, latency, "start to done latency");
        start = 1'b0;
    endtask

    task automatic runMultiply(input logic [3:0] m, input bit noisyStart);
        @(posedge clk);
        #1;
        mode  = m;
        start = 1'b1;
        waitForDone(m == strassenPkg::modeBrute ? latencyBrute : latencyStr, noisyStart);
    endtask

    task automatic checkResult(input int size);
        for (int addr = 0; addr < 16; addr++) begin
            @(posedge clk);
            #1;
            resultAddr = 4'(addr);
            #2;
            if (addr == 0)
                checkValue(int'(done), 0, "done still high after its pulse");
            checkValue(int'(resultOut), modelElement(size, addr / 4, addr % 4),
                       $sformatf("C[%0d][%0d]", addr / 4, addr % 4));
        end
    endtask

    // ==============================
    // Watchdog
    // ==============================
    initial begin
        repeat (numRuns * cyclesPerRun + 100) @(posedge clk);
        stopOnFailure("Simulation timed out before all tests finished");
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        logic [3:0] m;
        seed       = 32'hbd8e_f767;
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        mode       = 4'd0;
        memWrite   = 1'b0;
        memSelB    = 1'b0;
        memRow     = '0;
        memCol     = '0;
        memData    = '0;
        resultAddr = '0;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // After reset
        repeat (5) begin
            @(posedge clk);
            #1;
            checkValue(int'(state), 0, "state after reset");
            checkValue(int'(done), 0, "done after reset");
        end

        // Mode 2 with stray elements outside the corner
        loadOperands(1'b1);
        runMultiply(strassenPkg::modeBrute, 1'b0);
        checkResult(2);

        // Mode 4
        loadOperands(1'b0);
        runMultiply(strassenPkg::modeStrassen, 1'b0);
        checkResult(4);

        // Invalid mode holds the FSM in stCheck
        loadOperands(1'b0);
        @(posedge clk);
        #1;
        mode  = 4'd8;
        start = 1'b1;
        repeat (20) begin
            @(posedge clk);
            #1;
            start = 1'b0;
            checkValue(int'(state), 1, "state with invalid mode");
            checkValue(int'(done), 0, "done with invalid mode");
        end
        mode = strassenPkg::modeStrassen;
        waitForDone(8, 1'b0);
        checkResult(4);

        // Back-to-back runs with start noise while busy
        for (int run = 0; run < 40; run++) begin
            m = 1'($random(seed)) ? strassenPkg::modeStrassen : strassenPkg::modeBrute;
            loadOperands(1'b0);
            runMultiply(m, 1'b1);
            checkResult(m == strassenPkg::modeBrute ? 2 : 4);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* common/strassenPkg.sv */
`default_nettype none

package strassenPkg;

    // ==============================
    // Sizes and widths
    // ==============================
    localparam int matDim      = 4;
    localparam int halfDim     = 2;               // Quadrant edge
    localparam int elemWidth   = 4;
    localparam int resultWidth = 12;
    localparam int addrWidth   = 4;               // Flat C address
    localparam int idxWidth    = $clog2(matDim);  // Row or column index

    typedef logic [elemWidth-1:0]   elemT;
    typedef logic [resultWidth-1:0] resultT;

    typedef elemT   operandMatT [matDim][matDim];
    typedef resultT resultMatT  [matDim][matDim];
    typedef resultT quadT       [halfDim][halfDim];

    // ==============================
    // Modes and FSM states
    // ==============================
    localparam logic [3:0] modeBrute    = 4'd2;
    localparam logic [3:0] modeStrassen = 4'd4;

    // Code 5 unused, was the 8x8 select
    typedef enum logic [3:0] {
        stIdle  = 4'd0,
        stCheck = 4'd1,
        stSel2  = 4'd2,
        stBrute = 4'd3,
        stSel4  = 4'd4,
        stSlice = 4'd6,
        stCalc1 = 4'd7,
        stCalc2 = 4'd8,
        stComb1 = 4'd9,
        stComb2 = 4'd10,
        stLoadC = 4'd11,
        stDone  = 4'd12
    } stateT;

endpackage

`default_nettype wire

/* datapath/strassenDatapath.sv */
`timescale 1ns/1ns
`default_nettype none

module strassenDatapath (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    clearAll,
    input  wire logic                    ldBrute,
    input  wire logic                    ldSlice,
    input  wire logic                    ldCalc1,
    input  wire logic                    ldCalc2,
    input  wire logic                    ldComb1,
    input  wire logic                    ldComb2,
    input  wire strassenPkg::operandMatT opA,
    input  wire strassenPkg::operandMatT opB,
    output strassenPkg::resultMatT       result
);

    localparam int h = strassenPkg::halfDim;

    strassenPkg::quadT a11, a12, a21, a22, b11, b12, b21, b22;
    strassenPkg::quadT pSum1, pSum2, qSum, rDiff, sDiff, tSum, uDiff, uSum, vDiff, vSum;
    strassenPkg::quadT prodP, prodQ, prodR, prodS, prodT, prodU, prodV;
    strassenPkg::quadT pReg, qReg, rReg, sReg, tReg, uReg, vReg;
    strassenPkg::quadT c11, c12, c21, c22;

    strassenProducts i_strassenProducts (
        .pSum1 (pSum1), .pSum2 (pSum2), .qSum (qSum), .rDiff (rDiff), .sDiff (sDiff),
        .tSum  (tSum),  .uDiff (uDiff), .uSum (uSum), .vDiff (vDiff), .vSum  (vSum),
        .a11   (a11),   .a22   (a22),   .b11  (b11),  .b22   (b22),
        .prodP (prodP), .prodQ (prodQ), .prodR (prodR), .prodS (prodS),
        .prodT (prodT), .prodU (prodU), .prodV (prodV)
    );

    // ==============================
    // Strassen pipeline stages
    // ==============================
    always_ff @(posedge clk) begin
        for (int i = 0; i < h; i++) begin
            for (int j = 0; j < h; j++) begin
                if (clearAll) begin
                    a11[i][j] <= '0; a12[i][j] <= '0; a21[i][j] <= '0; a22[i][j] <= '0;
                    b11[i][j] <= '0; b12[i][j] <= '0; b21[i][j] <= '0; b22[i][j] <= '0;
                    pSum1[i][j] <= '0; pSum2[i][j] <= '0; qSum[i][j] <= '0;
                    rDiff[i][j] <= '0; sDiff[i][j] <= '0; tSum[i][j] <= '0;
                    uDiff[i][j] <= '0; uSum[i][j]  <= '0; vDiff[i][j] <= '0;
                    vSum[i][j]  <= '0;
                    pReg[i][j] <= '0; qReg[i][j] <= '0; rReg[i][j] <= '0; sReg[i][j] <= '0;
                    tReg[i][j] <= '0; uReg[i][j] <= '0; vReg[i][j] <= '0;
                    c11[i][j] <= '0; c12[i][j] <= '0; c21[i][j] <= '0; c22[i][j] <= '0;
                end else begin
                    if (ldSlice) begin
                        a11[i][j] <= strassenPkg::resultT'(opA[i][j]);
                        a12[i][j] <= strassenPkg::resultT'(opA[i][j+h]);
                        a21[i][j] <= strassenPkg::resultT'(opA[i+h][j]);
                        a22[i][j] <= strassenPkg::resultT'(opA[i+h][j+h]);
                        b11[i][j] <= strassenPkg::resultT'(opB[i][j]);
                        b12[i][j] <= strassenPkg::resultT'(opB[i][j+h]);
                        b21[i][j] <= strassenPkg::resultT'(opB[i+h][j]);
                        b22[i][j] <= strassenPkg::resultT'(opB[i+h][j+h]);
                    end
                    if (ldCalc1) begin
                        pSum1[i][j] <= a11[i][j] + a22[i][j];
                        pSum2[i][j] <= b11[i][j] + b22[i][j];
                        qSum[i][j]  <= a21[i][j] + a22[i][j];
                        rDiff[i][j] <= b12[i][j] - b22[i][j];
                        sDiff[i][j] <= b21[i][j] - b11[i][j];
                        tSum[i][j]  <= a11[i][j] + a12[i][j];
                        uDiff[i][j] <= a21[i][j] - a11[i][j];
                        uSum[i][j]  <= b11[i][j] + b12[i][j];
                        vDiff[i][j] <= a12[i][j] - a22[i][j];
                        vSum[i][j]  <= b21[i][j] + b22[i][j];
                    end
                    if (ldCalc2) begin
                        pReg[i][j] <= prodP[i][j]; qReg[i][j] <= prodQ[i][j];
                        rReg[i][j] <= prodR[i][j]; sReg[i][j] <= prodS[i][j];
                        tReg[i][j] <= prodT[i][j]; uReg[i][j] <= prodU[i][j];
                        vReg[i][j] <= prodV[i][j];
                    end
                    if (ldComb1) begin
                        c11[i][j] <= pReg[i][j] + sReg[i][j] - tReg[i][j] + vReg[i][j];
                        c12[i][j] <= rReg[i][j] + tReg[i][j];
                        c21[i][j] <= qReg[i][j] + sReg[i][j];
                        c22[i][j] <= pReg[i][j] + rReg[i][j] - qReg[i][j] + uReg[i][j];
                    end
                end
            end
        end
    end

    // Result matrix, brute force or placed quadrants
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < strassenPkg::matDim; i++)
                for (int j = 0; j < strassenPkg::matDim; j++)
                    result[i][j] <= '0;
        end else if (clearAll) begin
            for (int i = 0; i < strassenPkg::matDim; i++)
                for (int j = 0; j < strassenPkg::matDim; j++)
                    result[i][j] <= '0;
        end else begin
            for (int i = 0; i < h; i++) begin
                for (int j = 0; j < h; j++) begin
                    if (ldBrute) begin
                        result[i][j] <= strassenPkg::resultT'(opA[i][0]) * strassenPkg::resultT'(opB[0][j])
                                      + strassenPkg::resultT'(opA[i][1]) * strassenPkg::resultT'(opB[1][j]);
                    end else if (ldComb2) begin
                        result[i][j]     <= c11[i][j];
                        result[i][j+h]   <= c12[i][j];
                        result[i+h][j]   <= c21[i][j];
                        result[i+h][j+h] <= c22[i][j];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* datapath/strassenProducts.sv */
`timescale 1ns/1ns
`default_nettype none

module strassenProducts (
    input  wire strassenPkg::quadT pSum1,
    input  wire strassenPkg::quadT pSum2,
    input  wire strassenPkg::quadT qSum,
    input  wire strassenPkg::quadT rDiff,
    input  wire strassenPkg::quadT sDiff,
    input  wire strassenPkg::quadT tSum,
    input  wire strassenPkg::quadT uDiff,
    input  wire strassenPkg::quadT uSum,
    input  wire strassenPkg::quadT vDiff,
    input  wire strassenPkg::quadT vSum,
    input  wire strassenPkg::quadT a11,
    input  wire strassenPkg::quadT a22,
    input  wire strassenPkg::quadT b11,
    input  wire strassenPkg::quadT b22,
    output strassenPkg::quadT      prodP,
    output strassenPkg::quadT      prodQ,
    output strassenPkg::quadT      prodR,
    output strassenPkg::quadT      prodS,
    output strassenPkg::quadT      prodT,
    output strassenPkg::quadT      prodU,
    output strassenPkg::quadT      prodV
);

    // ==============================
    // Seven 2x2 products, mod 4096
    // ==============================
    always_comb begin
        for (int i = 0; i < strassenPkg::halfDim; i++) begin
            for (int j = 0; j < strassenPkg::halfDim; j++) begin
                prodP[i][j] = '0;
                prodQ[i][j] = '0;
                prodR[i][j] = '0;
                prodS[i][j] = '0;
                prodT[i][j] = '0;
                prodU[i][j] = '0;
                prodV[i][j] = '0;
                for (int k = 0; k < strassenPkg::halfDim; k++) begin
                    // P = (A11+A22)(B11+B22)
                    prodP[i][j] += pSum1[i][k] * pSum2[k][j];
                    // Q = (A21+A22)B11
                    prodQ[i][j] += qSum[i][k] * b11[k][j];
                    // R = A11(B12-B22)
                    prodR[i][j] += a11[i][k] * rDiff[k][j];
                    // S = A22(B21-B11)
                    prodS[i][j] += a22[i][k] * sDiff[k][j];
                    prodT[i][j] += tSum[i][k] * b22[k][j];    // (A11+A12)B22
                    prodU[i][j] += uDiff[i][k] * uSum[k][j];  // (A21-A11)(B11+B12)
                    prodV[i][j] += vDiff[i][k] * vSum[k][j];  // (A12-A22)(B21+B22)
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/matrixMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module matrixMemory (
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire logic                               memWrite,
    input  wire logic                               memSelB,    // 1 writes B, 0 writes A
    input  wire logic [strassenPkg::idxWidth-1:0]   memRow,
    input  wire logic [strassenPkg::idxWidth-1:0]   memCol,
    input  wire strassenPkg::elemT                  memData,
    input  wire logic                               ldOperands,
    input  wire logic [2:0]                         activeSize,
    input  wire logic                               writeResult,
    input  wire strassenPkg::resultMatT             result,
    input  wire logic [strassenPkg::addrWidth-1:0]  resultAddr,
    output strassenPkg::operandMatT                 opA,
    output strassenPkg::operandMatT                 opB,
    output strassenPkg::resultT                     resultOut
);

    strassenPkg::operandMatT memA, memB;
    strassenPkg::resultMatT  memC;

    logic [strassenPkg::idxWidth-1:0] readRow, readCol;

    // Element write port
    always_ff @(posedge clk) begin
        if (memWrite) begin
            if (memSelB) memB[memRow][memCol] <= memData;
            else         memA[memRow][memCol] <= memData;
        end
    end

    // Operand snapshot, masked to the active size
    always_ff @(posedge clk) begin
        if (ldOperands) begin
            for (int i = 0; i < strassenPkg::matDim; i++) begin
                for (int j = 0; j < strassenPkg::matDim; j++) begin
                    opA[i][j] <= (i < int'(activeSize) && j < int'(activeSize)) ?
                                 memA[i][j] : '0;
                    opB[i][j] <= (i < int'(activeSize) && j < int'(activeSize)) ?
                                 memB[i][j] : '0;
                end
            end
        end
    end

    // ==============================
    // Result store and readout
    // ==============================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < strassenPkg::matDim; i++)
                for (int j = 0; j < strassenPkg::matDim; j++)
                    memC[i][j] <= '0;
        end else if (writeResult) begin
            memC <= result;
        end
    end

    assign readRow   = resultAddr[strassenPkg::addrWidth-1 -: strassenPkg::idxWidth];
    assign readCol   = resultAddr[strassenPkg::idxWidth-1:0];
    assign resultOut = memC[readRow][readCol];

endmodule

`default_nettype wire

/* design/strassenControl.sv */
`timescale 1ns/1ns
`default_nettype none

module strassenControl (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          start,
    input  wire logic [3:0]    mode,
    output logic               done,
    output logic               ldOperands,
    output logic               ldBrute,
    output logic               ldSlice,
    output logic               ldCalc1,
    output logic               ldCalc2,
    output logic               ldComb1,
    output logic               ldComb2,
    output logic               writeResult,
    output logic               clearAll,
    output logic [2:0]         activeSize,
    output strassenPkg::stateT state
);

    strassenPkg::stateT nextState;
    logic [2:0] sizeReg;  // Size latched in stCheck

    // ==============================
    // State register
    // ==============================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= strassenPkg::stIdle;
            sizeReg <= '0;
        end else begin
            state <= nextState;
            if (state == strassenPkg::stCheck) begin
                if (mode == strassenPkg::modeBrute)
                    sizeReg <= 3'(strassenPkg::halfDim);
                else if (mode == strassenPkg::modeStrassen)
                    sizeReg <= 3'(strassenPkg::matDim);
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            strassenPkg::stIdle:  if (start) nextState = strassenPkg::stCheck;
            strassenPkg::stCheck: begin
                if (mode == strassenPkg::modeBrute)
                    nextState = strassenPkg::stSel2;
                else if (mode == strassenPkg::modeStrassen)
                    nextState = strassenPkg::stSel4;
            end
            strassenPkg::stSel2:  nextState = strassenPkg::stBrute;
            strassenPkg::stBrute: nextState = strassenPkg::stLoadC;
            strassenPkg::stSel4:  nextState = strassenPkg::stSlice;
            strassenPkg::stSlice: nextState = strassenPkg::stCalc1;
            strassenPkg::stCalc1: nextState = strassenPkg::stCalc2;
            strassenPkg::stCalc2: nextState = strassenPkg::stComb1;
            strassenPkg::stComb1: nextState = strassenPkg::stComb2;
            strassenPkg::stComb2: nextState = strassenPkg::stLoadC;
            strassenPkg::stLoadC: nextState = strassenPkg::stDone;
            strassenPkg::stDone:  nextState = strassenPkg::stIdle;
            default:              nextState = strassenPkg::stIdle;
        endcase
    end

    // ==============================
    // Moore outputs
    // ==============================
    assign clearAll    = (state == strassenPkg::stIdle);
    assign ldOperands  = (state == strassenPkg::stSel2) || (state == strassenPkg::stSel4);
    assign ldBrute     = (state == strassenPkg::stBrute);
    assign ldSlice     = (state == strassenPkg::stSlice);
    assign ldCalc1     = (state == strassenPkg::stCalc1);
    assign ldCalc2     = (state == strassenPkg::stCalc2);
    assign ldComb1     = (state == strassenPkg::stComb1);
    assign ldComb2     = (state == strassenPkg::stComb2);
    assign writeResult = (state == strassenPkg::stLoadC);
    assign done        = (state == strassenPkg::stDone);

    // Zero until the mode is decoded
    assign activeSize = (state == strassenPkg::stIdle || state == strassenPkg::stCheck) ?
                        3'd0 : sizeReg;

endmodule

`default_nettype wire

/* design/strassenTop.sv */
`timescale 1ns/1ns
`default_nettype none

module strassenTop (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                start,
    input  wire logic [3:0]                          mode,
    input  wire logic                                memWrite,
    input  wire logic                                memSelB,
    input  wire logic [strassenPkg::idxWidth-1:0]    memRow,
    input  wire logic [strassenPkg::idxWidth-1:0]    memCol,
    input  wire strassenPkg::elemT                   memData,
    input  wire logic [strassenPkg::addrWidth-1:0]   resultAddr,
    output logic                                     done,
    output strassenPkg::stateT                       state,
    output strassenPkg::resultT                      resultOut
);

    // Control strobes
    logic ldOperands, ldBrute, ldSlice, ldCalc1, ldCalc2, ldComb1, ldComb2;
    logic writeResult, clearAll;
    logic [2:0] activeSize;

    strassenPkg::operandMatT opA, opB;
    strassenPkg::resultMatT  result;

    strassenControl i_strassenControl (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .mode        (mode),
        .done        (done),
        .ldOperands  (ldOperands),
        .ldBrute     (ldBrute),
        .ldSlice     (ldSlice),
        .ldCalc1     (ldCalc1),
        .ldCalc2     (ldCalc2),
        .ldComb1     (ldComb1),
        .ldComb2     (ldComb2),
        .writeResult (writeResult),
        .clearAll    (clearAll),
        .activeSize  (activeSize),
        .state       (state)
    );

    matrixMemory i_matrixMemory (
        .clk         (clk),
        .reset       (reset),
        .memWrite    (memWrite),
        .memSelB     (memSelB),
        .memRow      (memRow),
        .memCol      (memCol),
        .memData     (memData),
        .ldOperands  (ldOperands),
        .activeSize  (activeSize),
        .writeResult (writeResult),
        .result      (result),
        .resultAddr  (resultAddr),
        .opA         (opA),
        .opB         (opB),
        .resultOut   (resultOut)
    );

    strassenDatapath i_strassenDatapath (
        .clk      (clk),
        .reset    (reset),
        .clearAll (clearAll),
        .ldBrute  (ldBrute),
        .ldSlice  (ldSlice),
        .ldCalc1  (ldCalc1),
        .ldCalc2  (ldCalc2),
        .ldComb1  (ldComb1),
        .ldComb2  (ldComb2),
        .opA      (opA),
        .opB      (opB),
        .result   (result)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal -f sim.f --top-module strassenTb \
    -o strassenSim > build.log 2>&1 &&
    ./obj_dir/strassenSim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim.f */
common/strassenPkg.sv
datapath/strassenProducts.sv
datapath/strassenDatapath.sv
design/strassenControl.sv
design/matrixMemory.sv
design/strassenTop.sv
bench/strassenTb.sv
